/* fe_pc_gen.f */
hw/fe_cfg_pkg.sv
hw/fe_isa_pkg.sv
hw/fe_instr_scan.sv
hw/fe_btb.sv
hw/fe_bht.sv
hw/fe_ras.sv
hw/fe_pc_gen.sv
dv/fe_pc_gen_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fe_pc_gen testbench with Verilator, run it, then scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module fe_pc_gen_tb -f fe_pc_gen.f -o fe_pc_gen_sim \
  && ./obj_dir/fe_pc_gen_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Test failures found" sim.log \
  && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }

/* dv/fe_pc_gen_golden.txt */
# wait rdr_v rdr_pc br_v taken is_br bht ras_ptr yumi fetch fetch_v att_v att_pc
#   exp_next_pc exp_ovr exp_fetch_pc exp_att_yumi mask(next,ovr,fetch,yumi)
1 0 00000000 0 0 0 0 0 0 00000000 0 1 00000100 00000004 0 00000000 0 f
100 0 00000000 0 0 0 0 0 0 00000000 0 1 00000100 00000004 0 00000000 0 f
30 0 00000000 0 0 0 0 0 0 00000000 0 1 00000100 00000004 0 00000000 1 f
1 0 00000000 0 0 0 0 0 0 00000000 0 0 00000000 00000004 0 00000000 0 f
1 0 00000000 0 0 0 0 0 1 00000000 0 0 00000000 00000004 0 00000000 0 f
1 0 00000000 0 0 0 0 0 1 00000000 0 0 00000000 00000008 0 00000000 0 f
1 0 00000000 0 0 0 0 0 1 00000000 0 0 00000000 0000000c 0 00000004 0 f
1 1 00000200 0 0 0 0 0 1 00000000 0 0 00000000 00000200 0 00000008 0 f
1 0 00000000 0 0 0 0 0 1 00000000 0 0 00000000 00000204 0 0000000c 0 f
1 0 00000000 0 0 0 0 0 1 00000000 0 0 00000000 00000208 0 00000200 0 f
1 1 00000300 1 1 1 2 0 0 00000000 0 0 00000000 00000300 0 00000204 0 f
1 1 00000300 1 1 1 2 0 0 00000000 0 0 00000000 00000300 0 00000204 0 f
1 1 00000300 0 0 0 0 0 1 00000000 0 0 00000000 00000300 0 00000204 0 f
1 0 00000000 0 0 0 0 0 0 00000000 0 0 00000000 00000300 0 00000208 0 f
1 1 00000300 1 0 1 1 0 0 00000000 0 0 00000000 00000300 0 00000208 0 f
1 1 00000300 0 0 0 0 0 1 00000000 0 0 00000000 00000300 0 00000208 0 f
1 0 00000000 0 0 0 0 0 0 00000000 0 0 00000000 00000304 0 00000300 0 f
1 0 00000000 0 0 0 0 0 0 0400006f 1 0 00000000 00000340 1 00000300 0 f
1 0 00000000 0 0 0 0 0 0 00000000 0 0 00000000 00000304 0 00000300 0 f
1 0 00000000 0 0 0 0 0 0 040000ef 1 0 00000000 00000340 1 00000300 0 f
1 0 00000000 0 0 0 0 0 0 00008067 1 0 00000000 00000304 1 00000300 0 f
1 0 00000000 0 0 0 0 0 1 00000000 0 0 00000000 00000304 0 00000300 0 f
1 0 00000000 0 0 0 0 0 1 00000000 0 0 00000000 00000308 0 00000300 0 f
1 1 00000400 1 0 0 0 1 0 040000ef 1 0 00000000 00000400 1 00000304 0 f
1 0 00000000 0 0 0 0 0 0 00008067 1 0 00000000 00000304 1 00000304 0 f
1 1 00000500 1 0 0 0 0 0 00000000 0 1 00000100 00000500 0 00000304 0 f
1 0 00000000 0 0 0 0 0 0 00000000 0 1 00000100 0000030c 0 00000304 1 f
1 0 00000000 0 0 0 0 0 0 00000000 0 0 00000000 0000030c 0 00000304 0 f

/* dv/fe_pc_gen_tb.sv */
/*
  fe_pc_gen testbench: replays golden vectors of stimulus and
  expected next-PC, override, fetch PC and attaboy strobe
*/
`timescale 1ns/1ps

module fe_pc_gen_tb;

  import fe_cfg_pkg::*;
  import fe_isa_pkg::*;

  localparam int max_vec     = 64;
  localparam int num_fld     = 17;
  localparam int clk_period  = 100;
  localparam int rst_cycles  = 10;
  localparam int init_cycles = 128;

  // Field positions within one vector line, after the wait count
  localparam int f_rv = 0;
  localparam int f_rpc = 1;
  localparam int f_bv = 2;
  localparam int f_tk = 3;
  localparam int f_ib = 4;
  localparam int f_bht = 5;
  localparam int f_rp = 6;
  localparam int f_y = 7;
  localparam int f_fetch = 8;
  localparam int f_fv = 9;
  localparam int f_av = 10;
  localparam int f_apc = 11;
  localparam int f_en = 12;
  localparam int f_eo = 13;
  localparam int f_ef = 14;
  localparam int f_ey = 15;
  localparam int f_mask = 16;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     init_done;
  logic                     redirect_v_i;
  logic [vaddr_width-1:0]   redirect_pc_i;
  logic                     redirect_br_v_i;
  logic                     redirect_taken_i;
  logic                     redirect_nonbr_i;
  logic                     redirect_is_br_i;
  logic                     redirect_is_jmp_i;
  logic                     redirect_src_btb_i;
  logic [1:0]               redirect_bht_val_i;
  logic [ghist_width-1:0]   redirect_ghist_i;
  logic [ras_ptr_width-1:0] redirect_ras_ptr_i;
  logic [vaddr_width-1:0]   next_pc;
  logic                     next_pc_yumi_i;
  logic                     ovr;
  logic [instr_width-1:0]   fetch_i;
  logic                     fetch_instr_v_i;
  logic [vaddr_width-1:0]   fetch_pc;
  logic                     fetch_src_btb;
  logic [1:0]               fetch_bht_val;
  logic [ghist_width-1:0]   fetch_ghist;
  logic [ras_ptr_width-1:0] fetch_ras_ptr;
  scan_class_e              fetch_class;
  logic                     attaboy_v_i;
  logic [vaddr_width-1:0]   attaboy_pc_i;
  logic                     attaboy_taken_i;
  logic                     attaboy_is_br_i;
  logic                     attaboy_is_jmp_i;
  logic                     attaboy_src_btb_i;
  logic [1:0]               attaboy_bht_val_i;
  logic [ghist_width-1:0]   attaboy_ghist_i;
  logic                     attaboy_yumi;

  int          vec_wait [max_vec];
  logic [31:0] vec_fld [max_vec][num_fld];
  int          num_vec;
  int          total_wait;
  int          timeout_ns;
  int          errors;
  int          checks;
  bit          load_ok;

  int                       rel_cycles;
  bit                       meta_v;
  scan_class_e              class_exp;
  logic [ras_ptr_width-1:0] ras_ptr_model;
  logic [ras_ptr_width-1:0] ras_ptr_exp;

  fe_pc_gen uut
    (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .init_done_o        (init_done),
    .redirect_v_i       (redirect_v_i),
    .redirect_pc_i      (redirect_pc_i),
    .redirect_br_v_i    (redirect_br_v_i),
    .redirect_taken_i   (redirect_taken_i),
    .redirect_nonbr_i   (redirect_nonbr_i),
    .redirect_is_br_i   (redirect_is_br_i),
    .redirect_is_jmp_i  (redirect_is_jmp_i),
    .redirect_src_btb_i (redirect_src_btb_i),
    .redirect_bht_val_i (redirect_bht_val_i),
    .redirect_ghist_i   (redirect_ghist_i),
    .redirect_ras_ptr_i (redirect_ras_ptr_i),
    .next_pc_o          (next_pc),
    .next_pc_yumi_i     (next_pc_yumi_i),
    .ovr_o              (ovr),
    .fetch_i            (fetch_i),
    .fetch_instr_v_i    (fetch_instr_v_i),
    .fetch_pc_o         (fetch_pc),
    .fetch_src_btb_o    (fetch_src_btb),
    .fetch_bht_val_o    (fetch_bht_val),
    .fetch_ghist_o      (fetch_ghist),
    .fetch_ras_ptr_o    (fetch_ras_ptr),
    .fetch_class_o      (fetch_class),
    .attaboy_v_i        (attaboy_v_i),
    .attaboy_pc_i       (attaboy_pc_i),
    .attaboy_taken_i    (attaboy_taken_i),
    .attaboy_is_br_i    (attaboy_is_br_i),
    .attaboy_is_jmp_i   (attaboy_is_jmp_i),
    .attaboy_src_btb_i  (attaboy_src_btb_i),
    .attaboy_bht_val_i  (attaboy_bht_val_i),
    .attaboy_ghist_i    (attaboy_ghist_i),
    .attaboy_yumi_o     (attaboy_yumi)
    );

  initial clk_i = 1'b0;

  always
  begin
    #(clk_period / 2) clk_i = ~clk_i;
  end

  // Expected predecode class from the opcode and link registers
  function automatic scan_class_e class_of(input logic [instr_width-1:0] instr);
    logic rd_link;
    logic rs1_link;
    begin
      rd_link  = (instr[11:7] == link_reg_x1) || (instr[11:7] == link_reg_x5);
      rs1_link = (instr[19:15] == link_reg_x1) || (instr[19:15] == link_reg_x5);
      case (instr[6:0])
        op_branch:
          class_of = scan_br;
        op_jal:
          class_of = rd_link ? scan_call : scan_jal;
        op_jalr:
        begin
          if (rd_link)
            class_of = scan_call;
          else if (rs1_link && (instr[11:7] == 5'd0))
            class_of = scan_ret;
          else
            class_of = scan_jalr;
        end
        default:
          class_of = scan_none;
      endcase
    end
  endfunction

  task automatic load_vectors();
    int          fd;
    int          cnt;
    int          w;
    string       line;
    logic [31:0] fld [num_fld];
    begin
      num_vec    = 0;
      total_wait = 0;
      load_ok    = 1'b0;
      fd = $fopen("dv/fe_pc_gen_golden.txt", "r");
      if (fd == 0)
        $display("Could not open the golden vector file");
      else
      begin
        load_ok = 1'b1;
        while (!$feof(fd) && (num_vec < max_vec))
        begin
          line = "";
          cnt  = $fgets(line, fd);
          if ((cnt > 1) && (line.getc(0) != "#"))
          begin
            cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          w, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                          fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                          fld[14], fld[15], fld[16]);
            if (cnt != num_fld + 1)
            begin
              $display("Malformed golden vector line: %s", line);
              load_ok = 1'b0;
            end
            else
            begin
              vec_wait[num_vec] = w;
              for (int i = 0; i < num_fld; i++)
                vec_fld[num_vec][i] = fld[i];
              total_wait = total_wait + w;
              num_vec    = num_vec + 1;
            end
          end
        end
        $fclose(fd);
        if (num_vec == 0)
        begin
          $display("Golden vector file holds no vectors");
          load_ok = 1'b0;
        end
      end
    end
  endtask

  task automatic apply_vector(input int n);
    begin
      redirect_v_i       <= vec_fld[n][f_rv][0];
      redirect_pc_i      <= vec_fld[n][f_rpc];
      redirect_br_v_i    <= vec_fld[n][f_bv][0];
      redirect_taken_i   <= vec_fld[n][f_tk][0];
      redirect_is_br_i   <= vec_fld[n][f_ib][0];
      redirect_bht_val_i <= vec_fld[n][f_bht][1:0];
      redirect_ras_ptr_i <= vec_fld[n][f_rp][ras_ptr_width-1:0];
      next_pc_yumi_i     <= vec_fld[n][f_y][0];
      fetch_i            <= vec_fld[n][f_fetch];
      fetch_instr_v_i    <= vec_fld[n][f_fv][0];
      attaboy_v_i        <= vec_fld[n][f_av][0];
      attaboy_pc_i       <= vec_fld[n][f_apc];
    end
  endtask

  // Watchdog sized from reset, the summed vector waits and some slack
  initial
  begin
    wait (timeout_ns != 0);
    #(timeout_ns);
    $display("Timeout: the vector replay did not finish in time");
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////
  // Init and metadata monitors
  //////////////////////////////
  always @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rel_cycles    <= 0;
      ras_ptr_model <= '0;
    end
    else
    begin
      rel_cycles <= rel_cycles + 1;
      if (fetch_instr_v_i)
      begin
        meta_v      <= 1'b1;
        class_exp   <= class_of(fetch_i);
        ras_ptr_exp <= ras_ptr_model;
      end
      // Restore beats push and pop
      if (redirect_br_v_i)
        ras_ptr_model <= redirect_ras_ptr_i;
      else if (fetch_instr_v_i && (class_of(fetch_i) == scan_call))
        ras_ptr_model <= ras_ptr_model + 1'b1;
      else if (fetch_instr_v_i && (class_of(fetch_i) == scan_ret))
        ras_ptr_model <= ras_ptr_model - 1'b1;
    end
  end

  always @(negedge clk_i)
  begin
    checks++;
    if (init_done !== (rel_cycles >= init_cycles))
    begin
      $display("** Error at %0t ns: init_done_o expected %b, got %b",
               $time, (rel_cycles >= init_cycles), init_done);
      errors++;
    end
    if (meta_v)
    begin
      checks += 2;
      if (fetch_class !== class_exp)
      begin
        $display("** Error at %0t ns: fetch_class_o expected %0d, got %0d",
                 $time, class_exp, fetch_class);
        errors++;
      end
      if (fetch_ras_ptr !== ras_ptr_exp)
      begin
        $display("** Error at %0t ns: fetch_ras_ptr_o expected %h, got %h",
                 $time, ras_ptr_exp, fetch_ras_ptr);
        errors++;
      end
    end
  end

  initial
  begin
    errors             = 0;
    checks             = 0;
    rst_n_i            = 1'b0;
    redirect_v_i       = 1'b0;
    redirect_pc_i      = '0;
    redirect_br_v_i    = 1'b0;
    redirect_taken_i   = 1'b0;
    redirect_nonbr_i   = 1'b0;
    redirect_is_br_i   = 1'b0;
    redirect_is_jmp_i  = 1'b0;
    redirect_src_btb_i = 1'b0;
    redirect_bht_val_i = 2'b00;
    redirect_ghist_i   = '0;
    redirect_ras_ptr_i = '0;
    next_pc_yumi_i     = 1'b0;
    fetch_i            = '0;
    fetch_instr_v_i    = 1'b0;
    attaboy_v_i        = 1'b0;
    attaboy_pc_i       = '0;
    attaboy_taken_i    = 1'b1;
    attaboy_is_br_i    = 1'b1;
    attaboy_is_jmp_i   = 1'b0;
    attaboy_src_btb_i  = 1'b1;
    attaboy_bht_val_i  = 2'b10;
    attaboy_ghist_i    = '0;

    load_vectors();
    if (!load_ok)
    begin
      $display("Golden vectors could not be loaded");
      $display("Test failures found");
      $finish;
    end
    else
    begin
      timeout_ns = (rst_cycles + total_wait + 200) * clk_period;
      repeat (rst_cycles) @(posedge clk_i);
      rst_n_i <= 1'b1;

      for (int n = 0; n < num_vec; n++)
      begin
        repeat (vec_wait[n]) @(posedge clk_i);
        apply_vector(n);
        @(negedge clk_i);
        if (vec_fld[n][f_mask][3])
        begin
          checks++;
          if (next_pc !== vec_fld[n][f_en])
          begin
            $display("** Error at %0t ns: next_pc_o expected %h, got %h (vector %0d)",
                     $time, vec_fld[n][f_en], next_pc, n);
            errors++;
          end
        end
        if (vec_fld[n][f_mask][2])
        begin
          checks++;
          if (ovr !== vec_fld[n][f_eo][0])
          begin
            $display("** Error at %0t ns: ovr_o expected %h, got %h (vector %0d)",
                     $time, vec_fld[n][f_eo][0], ovr, n);
            errors++;
          end
        end
        if (vec_fld[n][f_mask][1])
        begin
          checks++;
          if (fetch_pc !== vec_fld[n][f_ef])
          begin
            $display("** Error at %0t ns: fetch_pc_o expected %h, got %h (vector %0d)",
                     $time, vec_fld[n][f_ef], fetch_pc, n);
            errors++;
          end
        end
        if (vec_fld[n][f_mask][0])
        begin
          checks++;
          if (attaboy_yumi !== vec_fld[n][f_ey][0])
          begin
            $display("** Error at %0t ns: attaboy_yumi_o expected %h, got %h (vector %0d)",
                     $time, vec_fld[n][f_ey][0], attaboy_yumi, n);
            errors++;
          end
        end
      end

      // Let the monitors finish the last falling edge
      @(posedge clk_i);
      $display("Vectors: %0d, checks: %0d, errors: %0d", num_vec, checks, errors);
      if (errors == 0)
        $display("All tests passed!");
      else
        $display("Test failures found");
      $finish;
    end
  end

endmodule

/* hw/fe_pc_gen.sv */
/*
  Next-PC generator: picks the fetch address each cycle from redirect,
  predecode override, BTB/BHT prediction or PC plus 4, and trains the tables
*/
`timescale 1ns/1ps

module fe_pc_gen
  (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  output logic                                 init_done_o,

  input  logic                                 redirect_v_i,
  input  logic [fe_cfg_pkg::vaddr_width-1:0]   redirect_pc_i,
  input  logic                                 redirect_br_v_i,
  input  logic                                 redirect_taken_i,
  input  logic                                 redirect_nonbr_i,
  input  logic                                 redirect_is_br_i,
  input  logic                                 redirect_is_jmp_i,
  input  logic                                 redirect_src_btb_i,
  input  logic [1:0]                           redirect_bht_val_i,
  input  logic [fe_cfg_pkg::ghist_width-1:0]   redirect_ghist_i,
  input  logic [fe_cfg_pkg::ras_ptr_width-1:0] redirect_ras_ptr_i,

  output logic [fe_cfg_pkg::vaddr_width-1:0]   next_pc_o,
  input  logic                                 next_pc_yumi_i,
  output logic                                 ovr_o,

  input  logic [fe_cfg_pkg::instr_width-1:0]   fetch_i,
  input  logic                                 fetch_instr_v_i,
  output logic [fe_cfg_pkg::vaddr_width-1:0]   fetch_pc_o,
  output logic                                 fetch_src_btb_o,
  output logic [1:0]                           fetch_bht_val_o,
  output logic [fe_cfg_pkg::ghist_width-1:0]   fetch_ghist_o,
  output logic [fe_cfg_pkg::ras_ptr_width-1:0] fetch_ras_ptr_o,
  output fe_isa_pkg::scan_class_e              fetch_class_o,

  input  logic                                 attaboy_v_i,
  input  logic [fe_cfg_pkg::vaddr_width-1:0]   attaboy_pc_i,
  input  logic                                 attaboy_taken_i,
  input  logic                                 attaboy_is_br_i,
  input  logic                                 attaboy_is_jmp_i,
  input  logic                                 attaboy_src_btb_i,
  input  logic [1:0]                           attaboy_bht_val_i,
  input  logic [fe_cfg_pkg::ghist_width-1:0]   attaboy_ghist_i,
  output logic                                 attaboy_yumi_o
  );

  import fe_cfg_pkg::*;
  import fe_isa_pkg::*;

  logic [vaddr_width-1:0]   pc_if1_r;
  logic [vaddr_width-1:0]   pc_if2_r;
  logic [ghist_width-1:0]   ghist_r;
  logic [ghist_width-1:0]   ghist_cur;
  logic [ghist_width-1:0]   ghist_if1_r;
  logic [ghist_width-1:0]   ghist_if2_r;
  logic                     btb_hit_if2_r;
  logic [1:0]               bht_val_if2_r;
  logic                     ghist_we;

  scan_class_e              scan_class;
  logic [vaddr_width-1:0]   scan_imm;
  logic                     is_br;
  logic                     is_jal;
  logic                     is_call;
  logic                     is_ret;
  logic                     direct_jmp;
  logic [vaddr_width-1:0]   br_tgt;
  logic                     ovr_taken;
  logic                     ovr_ret;

  logic                     btb_init_done;
  logic [vaddr_width-1:0]   btb_tgt;
  logic                     btb_tgt_v;
  logic                     btb_jmp;
  logic                     btb_taken;
  logic                     btb_w_v;
  logic                     btb_w_clr;
  logic                     bht_init_done;
  logic [1:0]               bht_val;
  logic                     bht_w_v;

  logic [vaddr_width-1:0]   ras_top_pc;
  logic [ras_ptr_width-1:0] ras_top_ptr;

  logic                     att_ok;
  logic [vaddr_width-1:0]   train_pc;
  logic [ghist_width-1:0]   train_ghist;

  //////////////////////////////
  // Next PC select
  //////////////////////////////
  always_comb
  begin
    if (redirect_v_i)
      next_pc_o = redirect_pc_i;
    else if (ovr_ret)
      next_pc_o = ras_top_pc;
    else if (ovr_taken)
      next_pc_o = br_tgt;
    else if (btb_taken)
      next_pc_o = btb_tgt;
    else
      next_pc_o = pc_if1_r + vaddr_width'(4);
  end

  assign btb_taken = btb_tgt_v && (bht_val[1] || btb_jmp);

  // IF1 and IF2 advance together on each accepted PC
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      pc_if1_r      <= '0;
      pc_if2_r      <= '0;
      ghist_if1_r   <= '0;
      ghist_if2_r   <= '0;
      btb_hit_if2_r <= 1'b0;
      bht_val_if2_r <= bht_init_val;
    end
    else if (next_pc_yumi_i)
    begin
      pc_if1_r      <= next_pc_o;
      ghist_if1_r   <= ghist_cur;
      pc_if2_r      <= pc_if1_r;
      ghist_if2_r   <= ghist_if1_r;
      btb_hit_if2_r <= btb_tgt_v;
      bht_val_if2_r <= bht_val;
    end
  end

  //////////////////////////////
  // IF2 predecode and override
  //////////////////////////////
  fe_instr_scan u_scan
    (
    .fetch_i      (fetch_i),
    .scan_class_o (scan_class),
    .scan_imm_o   (scan_imm)
    );

  assign is_br   = fetch_instr_v_i && (scan_class == scan_br);
  assign is_jal  = fetch_instr_v_i && (scan_class == scan_jal);
  assign is_call = fetch_instr_v_i && (scan_class == scan_call);
  assign is_ret  = fetch_instr_v_i && (scan_class == scan_ret);

  // A jal call has a known target, a jalr call does not
  assign direct_jmp = is_jal || (is_call && (fetch_i[6:0] == op_jal));
  assign br_tgt     = pc_if2_r + scan_imm;

  assign ovr_taken = (pc_if1_r != br_tgt) && ((is_br && bht_val_if2_r[1]) || direct_jmp);
  assign ovr_ret   = (pc_if1_r != ras_top_pc) && is_ret;
  assign ovr_o     = ovr_taken || ovr_ret;

  assign fetch_pc_o = pc_if2_r;

  always_ff @(posedge clk_i)
  begin
    if (fetch_instr_v_i)
    begin
      fetch_src_btb_o <= btb_hit_if2_r;
      fetch_bht_val_o <= bht_val_if2_r;
      fetch_ghist_o   <= ghist_if2_r;
      fetch_ras_ptr_o <= ras_top_ptr;
      fetch_class_o   <= scan_class;
    end
  end

  // Global history
  assign ghist_we  = is_br || redirect_br_v_i;
  assign ghist_cur = !ghist_we ? ghist_r :
                     redirect_br_v_i ? redirect_ghist_i :
                     {ghist_r[ghist_width-2:0], bht_val_if2_r[1]};

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      ghist_r <= '0;
    else
      ghist_r <= ghist_cur;
  end

  //////////////////////////////
  // Training port
  //////////////////////////////
  assign att_ok         = attaboy_v_i && !redirect_br_v_i && init_done_o;
  assign attaboy_yumi_o = att_ok;

  assign train_pc    = redirect_br_v_i ? redirect_pc_i : attaboy_pc_i;
  assign train_ghist = redirect_br_v_i ? redirect_ghist_i : attaboy_ghist_i;

  assign btb_w_clr = redirect_br_v_i && redirect_nonbr_i && redirect_src_btb_i;
  assign btb_w_v   = (redirect_br_v_i && redirect_taken_i) || btb_w_clr
                     || (att_ok && attaboy_taken_i && !attaboy_src_btb_i);
  assign bht_w_v   = (redirect_br_v_i && redirect_is_br_i) || (att_ok && attaboy_is_br_i);

  fe_btb u_btb
    (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .init_done_o (btb_init_done),
    .r_v_i       (next_pc_yumi_i),
    .r_addr_i    (next_pc_o),
    .tgt_o       (btb_tgt),
    .tgt_v_o     (btb_tgt_v),
    .jmp_o       (btb_jmp),
    .w_v_i       (btb_w_v),
    .w_clr_i     (btb_w_clr),
    .w_jmp_i     (redirect_br_v_i ? redirect_is_jmp_i : attaboy_is_jmp_i),
    .w_tag_i     (train_pc[2 + btb_idx_width +: btb_tag_width]),
    .w_idx_i     (train_pc[2 +: btb_idx_width]),
    .w_tgt_i     (train_pc)
    );

  fe_bht u_bht
    (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .init_done_o (bht_init_done),
    .r_v_i       (next_pc_yumi_i),
    .r_idx_i     ({next_pc_o[2 +: bht_idx_width], ghist_cur}),
    .val_o       (bht_val),
    .w_v_i       (bht_w_v),
    .w_idx_i     ({train_pc[2 +: bht_idx_width], train_ghist}),
    .w_correct_i (redirect_br_v_i ? redirect_taken_i : attaboy_taken_i),
    .w_val_i     (redirect_br_v_i ? redirect_bht_val_i : attaboy_bht_val_i)
    );

  // Call pushes the return address of the IF2 instruction
  fe_ras u_ras
    (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .push_i        (is_call),
    .push_pc_i     (pc_if2_r + vaddr_width'(4)),
    .pop_i         (is_ret),
    .top_pc_o      (ras_top_pc),
    .top_ptr_o     (ras_top_ptr),
    .restore_i     (redirect_br_v_i),
    .restore_ptr_i (redirect_ras_ptr_i)
    );

  assign init_done_o = btb_init_done && bht_init_done;

endmodule

/* hw/fe_ras.sv */
/*
  Circular return-address stack; the top pointer can be
  restored from a checkpoint on a redirect
*/
`timescale 1ns/1ps

module fe_ras
  (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 push_i,
  input  logic [fe_cfg_pkg::vaddr_width-1:0]   push_pc_i,
  input  logic                                 pop_i,
  output logic [fe_cfg_pkg::vaddr_width-1:0]   top_pc_o,
  output logic [fe_cfg_pkg::ras_ptr_width-1:0] top_ptr_o,
  input  logic                                 restore_i,
  input  logic [fe_cfg_pkg::ras_ptr_width-1:0] restore_ptr_i
  );

  import fe_cfg_pkg::*;

  logic [vaddr_width-1:0]   stack_mem [ras_entries];
  logic [ras_ptr_width-1:0] ptr_r;
  logic [ras_ptr_width-1:0] ptr_inc;

  assign ptr_inc = ptr_r + 1'b1;

  // Restore beats push and pop
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      ptr_r <= '0;
    else if (restore_i)
      ptr_r <= restore_ptr_i;
    else if (push_i)
      ptr_r <= ptr_inc;
    else if (pop_i)
      ptr_r <= ptr_r - 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i && !restore_i)
      stack_mem[ptr_inc] <= push_pc_i;
  end

  assign top_pc_o  = stack_mem[ptr_r];
  assign top_ptr_o = ptr_r;

endmodule

/* hw/fe_bht.sv */
/*
  Bimodal direction table of two-bit saturating counters,
  swept to weakly-not-taken after reset
*/
`timescale 1ns/1ps

module fe_bht
  (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  output logic                                 init_done_o,
  input  logic                                 r_v_i,
  input  logic [fe_cfg_pkg::bht_row_width-1:0] r_idx_i,
  output logic [1:0]                           val_o,
  input  logic                                 w_v_i,
  input  logic [fe_cfg_pkg::bht_row_width-1:0] w_idx_i,
  input  logic                                 w_correct_i,
  input  logic [1:0]                           w_val_i
  );

  import fe_cfg_pkg::*;

  typedef enum logic {
    sweep_st,
    ready_st
  } state_e;

  state_e                   state_r;
  logic [bht_row_width-1:0] sweep_cnt_r;
  logic [1:0]               cnt_mem [bht_entries];
  logic [1:0]               val_r;
  logic [1:0]               w_new;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r     <= sweep_st;
      sweep_cnt_r <= '0;
    end
    else if (state_r == sweep_st)
    begin
      sweep_cnt_r <= sweep_cnt_r + 1'b1;
      if (&sweep_cnt_r)
        state_r <= ready_st;
    end
  end

  // Saturating step from the value the prediction carried
  always_comb
  begin
    if (w_correct_i)
      w_new = (w_val_i == 2'b11) ? 2'b11 : w_val_i + 2'b01;
    else
      w_new = (w_val_i == 2'b00) ? 2'b00 : w_val_i - 2'b01;
  end

  always_ff @(posedge clk_i)
  begin
    if (state_r == sweep_st)
      cnt_mem[sweep_cnt_r] <= bht_init_val;
    else if (w_v_i)
      cnt_mem[w_idx_i] <= w_new;
  end

  // Read sees the row before a same-cycle write lands
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      val_r <= bht_init_val;
    else if (r_v_i)
      val_r <= (state_r == ready_st) ? cnt_mem[r_idx_i] : bht_init_val;
  end

  assign val_o       = val_r;
  assign init_done_o = (state_r == ready_st);

endmodule

/* hw/fe_btb.sv */
/*
  Direct-mapped tagged branch target buffer.
  Valid bits are swept clear one entry per cycle after reset
*/
`timescale 1ns/1ps

module fe_btb
  (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  output logic                                 init_done_o,
  input  logic                                 r_v_i,
  input  logic [fe_cfg_pkg::vaddr_width-1:0]   r_addr_i,
  output logic [fe_cfg_pkg::vaddr_width-1:0]   tgt_o,
  output logic                                 tgt_v_o,
  output logic                                 jmp_o,
  input  logic                                 w_v_i,
  input  logic                                 w_clr_i,
  input  logic                                 w_jmp_i,
  input  logic [fe_cfg_pkg::btb_tag_width-1:0] w_tag_i,
  input  logic [fe_cfg_pkg::btb_idx_width-1:0] w_idx_i,
  input  logic [fe_cfg_pkg::vaddr_width-1:0]   w_tgt_i
  );

  import fe_cfg_pkg::*;

  typedef enum logic {
    sweep_st,
    ready_st
  } state_e;

  state_e                   state_r;
  logic [btb_idx_width-1:0] sweep_cnt_r;

  logic                     valid_mem [btb_entries];
  logic [btb_tag_width-1:0] tag_mem [btb_entries];
  logic                     jmp_mem [btb_entries];
  logic [vaddr_width-1:0]   tgt_mem [btb_entries];

  logic                     read_v_r;
  logic [btb_idx_width-1:0] read_idx_r;
  logic [btb_tag_width-1:0] read_tag_r;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r     <= sweep_st;
      sweep_cnt_r <= '0;
      read_v_r    <= 1'b0;
    end
    else
    begin
      if (state_r == sweep_st)
      begin
        sweep_cnt_r <= sweep_cnt_r + 1'b1;
        if (&sweep_cnt_r)
          state_r <= ready_st;
      end
      if (r_v_i)
        read_v_r <= 1'b1;
    end
  end

  // Sweep owns the arrays until every entry is invalid
  always_ff @(posedge clk_i)
  begin
    if (state_r == sweep_st)
      valid_mem[sweep_cnt_r] <= 1'b0;
    else if (w_v_i)
    begin
      valid_mem[w_idx_i] <= ~w_clr_i;
      tag_mem[w_idx_i]   <= w_tag_i;
      jmp_mem[w_idx_i]   <= w_jmp_i;
      tgt_mem[w_idx_i]   <= w_tgt_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
    begin
      read_idx_r <= r_addr_i[2 +: btb_idx_width];
      read_tag_r <= r_addr_i[2 + btb_idx_width +: btb_tag_width];
    end
  end

  assign tgt_v_o = read_v_r && (state_r == ready_st) && valid_mem[read_idx_r]
                   && (tag_mem[read_idx_r] == read_tag_r);
  assign tgt_o   = tgt_mem[read_idx_r];
  assign jmp_o   = jmp_mem[read_idx_r];

  assign init_done_o = (state_r == ready_st);

endmodule

/* hw/fe_instr_scan.sv */
/*
  Predecoder: classifies a fetched instruction and
  extracts its branch or jump immediate
*/
`timescale 1ns/1ps

module fe_instr_scan
  (
  input  logic [fe_cfg_pkg::instr_width-1:0] fetch_i,
  output fe_isa_pkg::scan_class_e            scan_class_o,
  output logic [fe_cfg_pkg::vaddr_width-1:0] scan_imm_o
  );

  import fe_isa_pkg::*;

  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rd_link;
  logic       rs1_link;

  assign rd  = fetch_i[11:7];
  assign rs1 = fetch_i[19:15];

  assign rd_link  = (rd == link_reg_x1) || (rd == link_reg_x5);
  assign rs1_link = (rs1 == link_reg_x1) || (rs1 == link_reg_x5);

  always_comb
  begin
    scan_class_o = scan_none;
    scan_imm_o   = '0;
    case (fetch_i[6:0])
      op_branch:
      begin
        scan_class_o = scan_br;
        scan_imm_o   = {{20{fetch_i[31]}}, fetch_i[7], fetch_i[30:25], fetch_i[11:8], 1'b0};
      end
      op_jal:
      begin
        scan_class_o = rd_link ? scan_call : scan_jal;
        scan_imm_o   = {{12{fetch_i[31]}}, fetch_i[19:12], fetch_i[20], fetch_i[30:21], 1'b0};
      end
      op_jalr:
      begin
        // Target comes from a register, so no immediate is useful here
        if (rd_link)
          scan_class_o = scan_call;
        else if (rs1_link && (rd == 5'd0))
          scan_class_o = scan_ret;
        else
          scan_class_o = scan_jalr;
      end
      default:
        scan_class_o = scan_none;
    endcase
  end

endmodule

/* hw/fe_isa_pkg.sv */
/*
  RISC-V control-flow opcodes and predecode classes
*/
package fe_isa_pkg;

  typedef enum logic [6:0] {
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111
  } opcode_e;

  // Classes reported by the predecoder
  typedef enum logic [2:0] {
    scan_none = 3'd0,
    scan_br   = 3'd1,
    scan_jal  = 3'd2,
    scan_jalr = 3'd3,
    scan_call = 3'd4,
    scan_ret  = 3'd5
  } scan_class_e;

  // ra and t0 act as link registers
  localparam logic [4:0] link_reg_x1 = 5'd1;
  localparam logic [4:0] link_reg_x5 = 5'd5;

endpackage

/* hw/fe_cfg_pkg.sv */
/*
  Fetch configuration: address, table and history sizes
*/
package fe_cfg_pkg;

  localparam int vaddr_width   = 32;
  localparam int instr_width   = 32;

  // Branch target buffer
  localparam int btb_idx_width = 4;
  localparam int btb_tag_width = 8;
  localparam int btb_entries   = 1 << btb_idx_width;

  // Direction table, indexed by PC bits and global history
  localparam int bht_idx_width = 5;
  localparam int ghist_width   = 2;
  localparam int bht_row_width = bht_idx_width + ghist_width;
  localparam int bht_entries   = 1 << bht_row_width;
  localparam logic [1:0] bht_init_val = 2'b01;

  // Return-address stack
  localparam int ras_entries   = 4;
  localparam int ras_ptr_width = 2;

endpackage
